// File: hw/uart_pkg.sv
package uart_pkg;

   // Line format: start, eight data bits LSB first, odd parity, stop
   localparam int frame_bits     = 11;
   localparam int frames_per_cmd = 2;

   // One command is sent as two frames, hi first
   typedef struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
   } uart_cmd_t;

   // Bit 0 is the first bit on the line
   typedef struct packed {
      logic       stop;
      logic       parity;
      logic [7:0] data;
      logic       start;
   } uart_fields_t;

   // Raw view for shifting, field view for building and checking
   typedef union packed {
      logic [frame_bits-1:0] raw;
      uart_fields_t          f;
   } uart_frame_u;

   typedef struct packed {
      logic load;
      logic shift;
   } tx_ctl_t;

   typedef struct packed {
      logic sample;
      logic done;
   } rx_ctl_t;

   // Bit that makes data plus parity hold an odd number of ones
   function automatic logic odd_parity(input logic [7:0] data);
      return ~^data;
   endfunction

endpackage

// File: hw/uart_ctrl.sv
`timescale 1ns/1ps

module uart_ctrl (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_vld,
   input  logic              line_low,
   output logic              cmd_rdy,
   output uart_pkg::tx_ctl_t tx_ctl,
   output uart_pkg::rx_ctl_t rx_ctl
);
   import uart_pkg::*;

   logic [4:0] tx_cnt;
   logic       tx_last;
   logic       rx_busy;
   logic [3:0] rx_cnt;
   logic       rx_last;

   // Transmit sequencer

   // Command taken in the cycle where both sides agree
   assign tx_ctl.load  = cmd_vld & cmd_rdy;

   // Line advances every cycle while busy
   assign tx_ctl.shift = ~cmd_rdy;

   assign tx_last = (tx_cnt == 5'(frames_per_cmd * frame_bits - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_rdy <= 1'b1;
      end else if (tx_ctl.load) begin
         cmd_rdy <= 1'b0;
      end else if (tx_ctl.shift && tx_last) begin
         cmd_rdy <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_cnt <= '0;
      end else if (tx_ctl.shift) begin
         if (tx_last) begin
            tx_cnt <= '0;
         end else begin
            tx_cnt <= tx_cnt + 5'd1;
         end
      end
   end

   // Receive sequencer

   // Start is only looked for while idle
   assign rx_ctl.sample = rx_busy | line_low;

   assign rx_last     = (rx_cnt == 4'(frame_bits - 1));
   assign rx_ctl.done = rx_ctl.sample & rx_last;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_busy <= 1'b0;
      end else if (rx_ctl.done) begin
         rx_busy <= 1'b0;
      end else if (rx_ctl.sample) begin
         rx_busy <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_cnt <= '0;
      end else if (rx_ctl.done) begin
         rx_cnt <= '0;
      end else if (rx_ctl.sample) begin
         rx_cnt <= rx_cnt + 4'd1;
      end
   end

endmodule

// File: hw/uart_tx_path.sv
`timescale 1ns/1ps

module uart_tx_path (
   input  logic                clk,
   input  logic                rst_n,
   input  uart_pkg::uart_cmd_t cmd_in,
   input  uart_pkg::tx_ctl_t   tx_ctl,
   output logic                tx
);
   import uart_pkg::*;

   uart_frame_u hi_frame;
   uart_frame_u lo_frame;

   function automatic uart_frame_u make_frame(input logic [7:0] data);
      uart_frame_u frame;
      frame.f.start  = 1'b0;
      frame.f.data   = data;
      frame.f.parity = odd_parity(data);
      frame.f.stop   = 1'b1;
      return frame;
   endfunction

   // The two frames form one 22-bit shifter, hi frame leaves first
   always_ff @(posedge clk) begin
      if (tx_ctl.load) begin
         hi_frame <= make_frame(cmd_in.hi);
         lo_frame <= make_frame(cmd_in.lo);
      end else if (tx_ctl.shift) begin
         hi_frame.raw <= {lo_frame.raw[0], hi_frame.raw[frame_bits-1:1]};
         lo_frame.raw <= {1'b1, lo_frame.raw[frame_bits-1:1]};
      end
   end

   // Idle line is high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx <= 1'b1;
      end else if (tx_ctl.shift) begin
         tx <= hi_frame.raw[0];
      end else begin
         tx <= 1'b1;
      end
   end

endmodule

// File: hw/uart_rx_path.sv
`timescale 1ns/1ps

module uart_rx_path (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              rx,
   input  uart_pkg::rx_ctl_t rx_ctl,
   output logic              line_low,
   output logic              read_rdy,
   output logic [7:0]        read_data
);
   import uart_pkg::*;

   logic        rx_meta;
   logic        rx_sync;
   uart_frame_u frame_q;
   uart_frame_u frame_nxt;
   logic        parity_ok;
   logic        frame_good;

   // Two-stage synchronizer, resting at the idle level
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   assign line_low = ~rx_sync;

   // New bit enters at the top, so the first bit ends up in bit 0
   assign frame_nxt.raw = {rx_sync, frame_q.raw[frame_bits-1:1]};

   always_ff @(posedge clk) begin
      if (rx_ctl.sample) begin
         frame_q <= frame_nxt;
      end
   end

   // Checked on the frame as it stands once the stop bit is in
   assign parity_ok  = (frame_nxt.f.parity == odd_parity(frame_nxt.f.data));
   assign frame_good = ~frame_nxt.f.start & frame_nxt.f.stop & parity_ok;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_rdy <= 1'b0;
      end else begin
         read_rdy <= rx_ctl.done & frame_good;
      end
   end

   // Bad frames leave the last good byte in place
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_data <= '0;
      end else if (rx_ctl.done && frame_good) begin
         read_data <= frame_nxt.f.data;
      end
   end

endmodule

// File: hw/uart.sv
`timescale 1ns/1ps

module uart (
   input  logic                clk,
   input  logic                rst_n,
   input  uart_pkg::uart_cmd_t cmd_in,
   input  logic                cmd_vld,
   input  logic                rx,
   output logic                cmd_rdy,
   output logic                tx,
   output logic                read_rdy,
   output logic [7:0]          read_data
);
   import uart_pkg::*;

   tx_ctl_t tx_ctl;
   rx_ctl_t rx_ctl;
   logic    line_low;

   // All bit counting lives here
   uart_ctrl u_ctrl (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd_vld  (cmd_vld),
      .line_low (line_low),
      .cmd_rdy  (cmd_rdy),
      .tx_ctl   (tx_ctl),
      .rx_ctl   (rx_ctl)
   );

   uart_tx_path u_tx (
      .clk    (clk),
      .rst_n  (rst_n),
      .cmd_in (cmd_in),
      .tx_ctl (tx_ctl),
      .tx     (tx)
   );

   uart_rx_path u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .rx        (rx),
      .rx_ctl    (rx_ctl),
      .line_low  (line_low),
      .read_rdy  (read_rdy),
      .read_data (read_data)
   );

endmodule

// File: bench/uart_clk_gen.sv
`timescale 1ns/1ps

module uart_clk_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset held for three rising edges, released off the edge
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
   end

endmodule

// File: bench/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

   localparam int line_bits   = 11;
   localparam int cmd_bits    = 22;
   localparam int read_lag    = 3;
   localparam int quiet_wait  = 15;
   localparam int per_test    = 40;
   localparam int base_cycles = 100;

   logic        clk;
   logic        rst_n;
   logic [15:0] cmd_in;
   logic        cmd_vld;
   logic        rx;
   logic        rx_drv;
   logic        loop_en;
   logic        cmd_rdy;
   logic        tx;
   logic        read_rdy;
   logic [7:0]  read_data;

   int          cycle_cnt = 0;
   int          rdy_cycle[$];
   logic [7:0]  rdy_data[$];
   string       t_name[$];
   string       t_mode[$];
   logic [15:0] t_value[$];
   logic [15:0] t_aux[$];
   int          t_flag[$];
   logic [7:0]  last_data;
   bit          tests_ready = 1'b0;

   uart_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   uart u_uart (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_in    (cmd_in),
      .cmd_vld   (cmd_vld),
      .rx        (rx),
      .cmd_rdy   (cmd_rdy),
      .tx        (tx),
      .read_rdy  (read_rdy),
      .read_data (read_data)
   );

   // Loop mode feeds the transmitter straight back
   assign rx = loop_en ? tx : rx_drv;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // Read strobes are logged mid-cycle with the edge they followed
   always @(negedge clk) begin
      if (read_rdy === 1'b1) begin
         rdy_cycle.push_back(cycle_cnt);
         rdy_data.push_back(read_data);
      end
   end

   task automatic wait_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("FAIL %s %s: expected %0h, actual %0h", name, what, exp, act);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   // Odd parity by counting ones
   function automatic logic parity_bit_of(input logic [7:0] b);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         ones += b[i];
      end
      return (ones % 2 == 0);
   endfunction

   function automatic logic [10:0] line_frame(input logic [7:0] b);
      return {1'b1, parity_bit_of(b), b, 1'b0};
   endfunction

   task automatic read_tests();
      int          fd;
      int          n;
      int          ch;
      string       name;
      string       mode;
      logic [15:0] value;
      logic [15:0] aux;
      int          flag;
      fd = $fopen("bench/uart_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file bench/uart_testdata.txt");
         $display("Checks failed");
         $fatal(1);
      end else begin
         while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", name);
            if (n == 1 && name.substr(0, 0) == "#") begin
               ch = $fgetc(fd);
               while (ch != "\n" && ch != -1) begin
                  ch = $fgetc(fd);
               end
            end else if (n == 1) begin
               n = $fscanf(fd, "%s %h %h %d", mode, value, aux, flag);
               t_name.push_back(name);
               t_mode.push_back(mode);
               t_value.push_back(value);
               t_aux.push_back(aux);
               t_flag.push_back(flag);
            end
         end
         $fclose(fd);
      end
   endtask

   // One command, then the 22 line bits after acceptance
   task automatic send_command(input string name, input logic [15:0] value,
                               input logic hold, input logic [15:0] held,
                               output int accept_cycle);
      logic [21:0] seen;
      logic [21:0] expected;
      expected = {line_frame(value[7:0]), line_frame(value[15:8])};
      check_value(name, "cmd_rdy before command", 1, cmd_rdy);
      cmd_in  = value;
      cmd_vld = 1'b1;
      wait_cycle();
      accept_cycle = cycle_cnt;
      if (hold) begin
         cmd_in = held;
      end else begin
         cmd_vld = 1'b0;
      end
      check_value(name, "cmd_rdy after accept", 0, cmd_rdy);
      for (int k = 0; k < cmd_bits; k++) begin
         wait_cycle();
         seen[k] = tx;
         check_value(name, "cmd_rdy during send", (k == cmd_bits - 1), cmd_rdy);
      end
      check_value(name, "tx bits", expected, seen);
   endtask

   task automatic command_test(input int t);
      int acc;
      send_command(t_name[t], t_value[t], t_flag[t] != 0, t_aux[t], acc);
      if (t_flag[t] != 0) begin
         // The request held while busy goes in on the first free edge
         send_command(t_name[t], t_aux[t], 1'b0, '0, acc);
      end
      check_value(t_name[t], "read strobes", 0, rdy_cycle.size());
   endtask

   task automatic loopback_test(input int t);
      int          acc;
      logic [15:0] v;
      v       = t_value[t];
      loop_en = 1'b1;
      send_command(t_name[t], v, 1'b0, '0, acc);
      while (cycle_cnt < acc + cmd_bits + read_lag + 2) begin
         wait_cycle();
      end
      loop_en = 1'b0;
      check_value(t_name[t], "read strobes", 2, rdy_cycle.size());
      check_value(t_name[t], "hi read cycle", acc + line_bits + read_lag, rdy_cycle[0]);
      check_value(t_name[t], "hi read data", v[15:8], rdy_data[0]);
      check_value(t_name[t], "lo read cycle", acc + cmd_bits + read_lag, rdy_cycle[1]);
      check_value(t_name[t], "lo read data", v[7:0], rdy_data[1]);
      check_value(t_name[t], "read_data", v[7:0], read_data);
      last_data = v[7:0];
   endtask

   task automatic frame_test(input int t);
      logic [15:0] aux;
      logic [10:0] raw;
      logic        good;
      int          stop_cycle;
      aux  = t_aux[t];
      raw  = aux[10:0];
      good = (t_flag[t] != 0);
      check_value(t_name[t], "good flag in test data", good,
                  (raw[0] == 1'b0) && raw[10] && (raw[9] == parity_bit_of(raw[8:1])));
      for (int i = 0; i < line_bits; i++) begin
         wait_cycle();
         rx_drv = raw[i];
      end
      stop_cycle = cycle_cnt;
      wait_cycle();
      rx_drv = 1'b1;
      while (cycle_cnt < stop_cycle + quiet_wait) begin
         wait_cycle();
      end
      if (good) begin
         check_value(t_name[t], "read strobes", 1, rdy_cycle.size());
         check_value(t_name[t], "read cycle", stop_cycle + read_lag, rdy_cycle[0]);
         check_value(t_name[t], "read data", raw[8:1], rdy_data[0]);
         check_value(t_name[t], "read_data", raw[8:1], read_data);
         last_data = raw[8:1];
      end else begin
         check_value(t_name[t], "read strobes", 0, rdy_cycle.size());
         check_value(t_name[t], "read_data kept", last_data, read_data);
      end
   endtask

   // Budget grows with the number of tests read
   initial begin
      wait (tests_ready);
      repeat (t_name.size() * per_test + base_cycles) @(posedge clk);
      $display("Timeout: the tests did not finish in the allowed number of cycles");
      $display("Checks failed");
      $fatal(1);
   end

   initial begin
      int seed;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      rx_drv    = 1'b1;
      loop_en   = 1'b0;
      last_data = '0;
      seed      = $urandom(32'hff1e);
      read_tests();
      tests_ready = 1'b1;
      wait (rst_n === 1'b1);
      wait_cycle();
      check_value("reset", "tx", 1, tx);
      check_value("reset", "cmd_rdy", 1, cmd_rdy);
      check_value("reset", "read_rdy", 0, read_rdy);
      check_value("reset", "read_data", 0, read_data);
      for (int t = 0; t < t_name.size(); t++) begin
         repeat ($urandom % 6) wait_cycle();
         rdy_cycle.delete();
         rdy_data.delete();
         if (t_mode[t] == "cmd") begin
            command_test(t);
         end else if (t_mode[t] == "loop") begin
            loopback_test(t);
         end else if (t_mode[t] == "frame") begin
            frame_test(t);
         end else begin
            $display("Test %s has an unknown mode %s", t_name[t], t_mode[t]);
            $display("Checks failed");
            $fatal(1);
         end
      end
      $display("All checks passed");
      $finish;
   end

endmodule

// File: uart.f
hw/uart_pkg.sv
hw/uart_ctrl.sv
hw/uart_tx_path.sv
hw/uart_rx_path.sv
hw/uart.sv
bench/uart_clk_gen.sv
bench/uart_tb.sv

// File: bench/uart_testdata.txt
# columns: name mode value aux flag, with value and aux in hex
# cmd lines hold aux on cmd_in while busy when flag is 1, frame lines give the raw frame in aux
cmd_zero cmd 0000 0000 0
cmd_ones cmd ffff 0000 0
cmd_alt cmd 55aa 0000 0
cmd_alt_inv cmd aa55 0000 0
cmd_hi_only cmd 8000 0000 0
cmd_lo_only cmd 0001 0000 0
cmd_mixed cmd 1234 0000 0
cmd_mixed2 cmd beef 0000 0
cmd_busy_a cmd 0f0f f0f0 1
cmd_busy_b cmd c3a5 5a3c 1
cmd_busy_c cmd 0000 ffff 1
cmd_back cmd 7e81 0000 0
loop_zero loop 0000 0000 0
loop_ones loop ffff 0000 0
loop_mixed loop 1234 0000 0
loop_alt loop a55a 0000 0
loop_one_bit loop 0180 0000 0
loop_c3 loop c33c 0000 0
frame_good_00 frame 0000 0600 1
frame_good_ff frame 0000 07fe 1
frame_good_55 frame 0000 06aa 1
frame_good_a5 frame 0000 074a 1
frame_good_01 frame 0000 0402 1
frame_good_80 frame 0000 0500 1
frame_good_3c frame 0000 0678 1
frame_bad_par_00 frame 0000 0400 0
frame_bad_par_55 frame 0000 04aa 0
frame_good_7e frame 0000 06fc 1
frame_bad_par_01 frame 0000 0602 0
frame_bad_stop_5a frame 0000 02b4 0
frame_good_13 frame 0000 0426 1
frame_bad_stop_80 frame 0000 0100 0
frame_bad_par_13 frame 0000 0626 0
frame_glitch frame 0000 05fd 0
frame_no_start frame 0000 07ff 0
frame_good_c8 frame 0000 0590 1
frame_bad_stop_ff frame 0000 03fe 0
loop_after_frames loop 9d62 0000 0
